/* zip_dbg_pkg.sv */
/*
 * Shared definitions for the AXI-lite debug port of the CPU wrapper.
 * Holds bus widths, the word address decode, the command and status bit
 * positions, the reset hold length and the debug write word union.
 * Modules import it by wildcard in their body.
 */
`default_nettype none

package zip_dbg_pkg;

	// Debug bus geometry
	localparam int DBG_ADDR_W  = 8;
	localparam int DBG_DATA_W  = 32;
	localparam int DBG_STRB_W  = DBG_DATA_W / 8;
	localparam int DBG_LSB     = 2;
	localparam int DBG_WADDR_W = DBG_ADDR_W - DBG_LSB;

	// Word address decode
	localparam int CTL_SEL_BIT = 5;
	localparam int REG_IDX_W   = 5;
	localparam int CC_W        = 3;

	// Command word bits
	localparam int RESET_BIT       = 6;
	localparam int STEP_BIT        = 8;
	localparam int HALT_BIT        = 10;
	localparam int CLEAR_CACHE_BIT = 11;

	// Status word bits
	localparam int ST_RESET_BIT  = 6;
	localparam int ST_IRQ_BIT    = 7;
	localparam int ST_RUN_BIT    = 9;
	localparam int ST_HALT_BIT   = 10;
	localparam int ST_CC_LSB     = 12;
	localparam int ST_BREAK_BIT  = 15;
	localparam int ST_IRQ_HI_BIT = 16;

	// Power-up reset hold and halt-on-start policy
	localparam int RESET_DURATION = 10;
	localparam int RST_CNT_W      = $clog2(RESET_DURATION + 1);
	localparam logic START_HALTED = 1'b0;

	// Debug write word, seen as register data or as a command
	typedef union packed {
		logic [DBG_DATA_W-1:0] data;
		struct packed {
			logic [DBG_DATA_W-CLEAR_CACHE_BIT-2:0] pad_hi;
			logic clear_cache;
			logic halt;
			logic rsvd_9;
			logic step;
			logic rsvd_7;
			logic reset;
			logic [RESET_BIT-1:0] pad_lo;
		} cmd;
	} dbg_word_u;

endpackage

`default_nettype wire

/* dbg_req_if.sv */
/*
 * Accepted debug writes, passed from the AXI-lite write path to the
 * CPU control block. The write path drives, the control block listens.
 */
`default_nettype none

interface dbg_req_if;
	import zip_dbg_pkg::*;

	logic write_accept;
	logic cmd_write;
	logic reg_write;
	logic [DBG_STRB_W-1:0] strb;
	dbg_word_u word;
	// Core register write still outstanding
	logic reg_busy;

	modport wr (output write_accept, cmd_write, reg_write, strb, word, reg_busy);
	modport ctl (input write_accept, cmd_write, reg_write, strb, word, reg_busy);

endinterface

`default_nettype wire

/* skid_buffer.sv */
/*
 * One-deep valid/ready skid buffer.
 * Passes data straight through while empty and parks one item when the
 * downstream side stalls, so the upstream ready comes from a flop.
 */
`default_nettype none

module skid_buffer #(
	parameter int DW = 8
) (
	input  wire logic          S_AXI_ACLK,
	input  wire logic          S_AXI_ARESETN,
	input  wire logic          i_valid,
	output logic               o_ready,
	input  wire logic [DW-1:0] i_data,
	output logic               o_valid,
	input  wire logic          i_ready,
	output logic [DW-1:0]      o_data
);

	logic          r_valid;
	logic [DW-1:0] r_data;

	// Park an item when it arrives and the far side stalls
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (i_valid && o_ready && !i_ready)
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	// Only load while empty
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
			r_data <= i_data;
	end

	assign o_ready = !r_valid;
	assign o_valid = i_valid || r_valid;
	assign o_data  = r_valid ? r_data : i_data;

	// A stalled item stays put until taken
	a_hold_stable: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(o_valid && !i_ready) |=> (o_valid && $stable(o_data)));

endmodule

`default_nettype wire

/* dbg_write_path.sv */
/*
 * AXI-lite debug write channel.
 * Joins AW and W, splits control writes from CPU register writes, issues
 * register writes to the core debug port and returns the B response.
 */
`default_nettype none

module dbg_write_path (
	input  wire logic                             S_AXI_ACLK,
	input  wire logic                             S_AXI_ARESETN,
	input  wire logic                             i_awvalid,
	output logic                                  o_awready,
	input  wire logic [zip_dbg_pkg::DBG_ADDR_W-1:0] i_awaddr,
	input  wire logic                             i_wvalid,
	output logic                                  o_wready,
	input  wire logic [zip_dbg_pkg::DBG_DATA_W-1:0] i_wdata,
	input  wire logic [zip_dbg_pkg::DBG_STRB_W-1:0] i_wstrb,
	output logic                                  o_bvalid,
	input  wire logic                             i_bready,
	input  wire logic                             i_core_stall,
	output logic                                  o_core_we,
	output logic [zip_dbg_pkg::REG_IDX_W-1:0]     o_core_wreg,
	output logic [zip_dbg_pkg::DBG_DATA_W-1:0]    o_core_wdata,
	dbg_req_if.wr                                 req
);
	import zip_dbg_pkg::*;

	logic                   aw_valid, w_valid, accept, write_stall, ctl_sel;
	logic [DBG_WADDR_W-1:0] aw_addr;
	logic [DBG_DATA_W-1:0]  w_data;
	logic [DBG_STRB_W-1:0]  w_strb;

	//////////////////////////////
	// Channel buffers
	//////////////////////////////

	// Byte offset dropped, word address only
	skid_buffer #(.DW(DBG_WADDR_W)) u_aw_skid (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_awvalid), .o_ready(o_awready),
		.i_data(i_awaddr[DBG_ADDR_W-1:DBG_LSB]),
		.o_valid(aw_valid), .i_ready(accept), .o_data(aw_addr)
	);

	skid_buffer #(.DW(DBG_DATA_W + DBG_STRB_W)) u_w_skid (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_wvalid), .o_ready(o_wready),
		.i_data({i_wdata, i_wstrb}),
		.o_valid(w_valid), .i_ready(accept), .o_data({w_data, w_strb})
	);

	//////////////////////////////
	// Join and issue
	//////////////////////////////

	assign ctl_sel     = aw_addr[CTL_SEL_BIT];
	// Core has not yet taken the last register write
	assign write_stall = o_core_we && i_core_stall;

	assign accept = aw_valid && w_valid
		&& ((w_strb == '0) || ctl_sel || !write_stall)
		&& (!o_bvalid || i_bready);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_core_we <= 1'b0;
		else if (!write_stall)
			o_core_we <= accept && (|w_strb) && !ctl_sel;
	end

	// Index and data hold with the write strobe
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!write_stall)
		begin
			o_core_wreg  <= aw_addr[REG_IDX_W-1:0];
			o_core_wdata <= w_data;
		end
	end

	// B response, always OKAY
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_bvalid <= 1'b0;
		else if (accept)
			o_bvalid <= 1'b1;
		else if (i_bready)
			o_bvalid <= 1'b0;
	end

	// To the control block
	assign req.write_accept = accept;
	assign req.cmd_write    = accept && ctl_sel;
	assign req.reg_write    = accept && !ctl_sel && (|w_strb);
	assign req.strb         = w_strb;
	assign req.word         = dbg_word_u'(w_data);
	assign req.reg_busy     = o_core_we;

	a_we_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(o_core_we && i_core_stall) |=>
			(o_core_we && $stable(o_core_wreg) && $stable(o_core_wdata)));

endmodule

`default_nettype wire

/* dbg_read_path.sv */
/*
 * AXI-lite debug read channel.
 * The control address returns the status word one cycle after the
 * request. A CPU register address reads the core and answers a cycle later.
 */
`default_nettype none

module dbg_read_path (
	input  wire logic                             S_AXI_ACLK,
	input  wire logic                             S_AXI_ARESETN,
	input  wire logic                             i_arvalid,
	output logic                                  o_arready,
	input  wire logic [zip_dbg_pkg::DBG_ADDR_W-1:0] i_araddr,
	output logic                                  o_rvalid,
	input  wire logic                             i_rready,
	output logic [zip_dbg_pkg::DBG_DATA_W-1:0]    o_rdata,
	output logic [zip_dbg_pkg::REG_IDX_W-1:0]     o_core_rreg,
	input  wire logic [zip_dbg_pkg::DBG_DATA_W-1:0] i_core_rdata,
	input  wire logic [zip_dbg_pkg::DBG_DATA_W-1:0] i_status
);
	import zip_dbg_pkg::*;

	logic                   ar_valid, read_accept, rd_pending;
	logic [DBG_WADDR_W-1:0] ar_addr;
	logic [DBG_DATA_W-1:0]  rd_data_q;

	skid_buffer #(.DW(DBG_WADDR_W)) u_ar_skid (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_arvalid), .o_ready(o_arready),
		.i_data(i_araddr[DBG_ADDR_W-1:DBG_LSB]),
		.o_valid(ar_valid), .i_ready(read_accept), .o_data(ar_addr)
	);

	// One read in flight, and R must be free or leaving
	assign read_accept = ar_valid && !rd_pending && (!o_rvalid || i_rready);
	assign o_core_rreg = ar_addr[REG_IDX_W-1:0];

	// Register read waiting one more cycle
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rd_pending <= 1'b0;
		else
			rd_pending <= read_accept && !ar_addr[CTL_SEL_BIT];
	end

	// Core data sampled while the index is still on the port
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (read_accept)
			rd_data_q <= i_core_rdata;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_rvalid <= 1'b0;
		else if (!o_rvalid || i_rready)
			o_rvalid <= (read_accept && ar_addr[CTL_SEL_BIT]) || rd_pending;
	end

	// R payload, held under back-pressure
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_rvalid || i_rready)
			o_rdata <= rd_pending ? rd_data_q : i_status;
	end

	a_one_in_flight: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		!(rd_pending && o_rvalid));

endmodule

`default_nettype wire

/* cpu_control.sv */
/*
 * CPU reset, halt, step and clear-cache control.
 * Holds the core in reset after power-up, decodes debug command writes
 * and builds the status word returned on a control address read.
 */
`default_nettype none

module cpu_control (
	input  wire logic                          S_AXI_ACLK,
	input  wire logic                          S_AXI_ARESETN,
	input  wire logic                          i_cpu_reset,
	input  wire logic                          i_interrupt,
	input  wire logic                          i_core_break,
	input  wire logic                          i_core_stall,
	input  wire logic [zip_dbg_pkg::CC_W-1:0]  i_core_cc,
	dbg_req_if.ctl                             req,
	output logic                               o_core_reset,
	output logic                               o_core_halt,
	output logic                               o_core_clear_cache,
	output logic [zip_dbg_pkg::DBG_DATA_W-1:0] o_status
);
	import zip_dbg_pkg::*;

	logic [RST_CNT_W-1:0] rst_cnt;
	logic reset_hold, cmd_reset, cmd_halt, cmd_step, cmd_clear_cache;
	logic reset_req, halt_req, halt_clr_req, step_req, clear_req, write_stall;

	//////////////////////////////
	// Command decode
	//////////////////////////////

	// Each command bit counts only with its byte lane enabled
	assign reset_req    = req.cmd_write && req.strb[RESET_BIT/8] && req.word.cmd.reset;
	assign halt_req     = req.cmd_write && req.strb[HALT_BIT/8] && req.word.cmd.halt;
	assign halt_clr_req = req.cmd_write && req.strb[HALT_BIT/8] && !req.word.cmd.halt;
	assign step_req     = req.cmd_write && req.strb[STEP_BIT/8] && req.word.cmd.step;
	assign clear_req    = req.cmd_write && req.strb[CLEAR_CACHE_BIT/8]
		&& req.word.cmd.clear_cache;
	assign write_stall  = req.reg_busy && i_core_stall;

	//////////////////////////////
	// Reset hold
	//////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
		begin
			rst_cnt    <= RST_CNT_W'(RESET_DURATION);
			reset_hold <= 1'b1;
		end
		else
		begin
			if (rst_cnt != '0)
				rst_cnt <= rst_cnt - 1'b1;
			// Drops on the same edge the count reaches zero
			reset_hold <= (rst_cnt > 1);
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset || reset_hold)
			cmd_reset <= 1'b1;
		else if (i_core_break && !START_HALTED)
			cmd_reset <= 1'b1;
		else
			cmd_reset <= reset_req;
	end

	//////////////////////////////
	// Halt, step, clear cache
	//////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			cmd_halt <= START_HALTED;
		else if (i_cpu_reset && !req.write_accept && !write_stall)
			cmd_halt <= START_HALTED;
		else if (cmd_reset && START_HALTED)
			cmd_halt <= START_HALTED;
		else
		begin
			// Release only once no register write is pending
			if (!req.reg_busy && !i_core_stall && (halt_clr_req || step_req))
				cmd_halt <= 1'b0;
			// Exceptions halt when starting halted, else they reset
			if (i_core_break && START_HALTED)
				cmd_halt <= 1'b1;
			if (halt_req && !req.word.cmd.step)
				cmd_halt <= 1'b1;
			// Registers change only in a halted core
			if (req.reg_write)
				cmd_halt <= 1'b1;
			if (cmd_step || cmd_clear_cache || clear_req)
				cmd_halt <= 1'b1;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || cmd_reset)
			cmd_clear_cache <= 1'b0;
		else if (clear_req && halt_req)
			cmd_clear_cache <= 1'b1;
		else if (cmd_halt && !i_core_stall)
			cmd_clear_cache <= 1'b0;
	end

	// One instruction, then back to halt
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || i_cpu_reset)
			cmd_step <= 1'b0;
		else if (step_req)
			cmd_step <= 1'b1;
		else if (!i_core_stall)
			cmd_step <= 1'b0;
	end

	// Status word, unused bits read zero
	always_comb
	begin
		o_status = '0;
		o_status[ST_RESET_BIT] = cmd_reset;
		o_status[ST_IRQ_BIT] = i_interrupt;
		o_status[ST_RUN_BIT] = !i_core_stall;
		o_status[ST_HALT_BIT] = cmd_halt;
		o_status[ST_CC_LSB +: CC_W] = i_core_cc;
		o_status[ST_BREAK_BIT] = i_core_break;
		o_status[ST_IRQ_HI_BIT] = i_interrupt;
	end

	assign o_core_reset       = cmd_reset;
	assign o_core_halt        = cmd_halt;
	assign o_core_clear_cache = cmd_clear_cache;

	a_hold_count: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		reset_hold == (rst_cnt != '0));

endmodule

`default_nettype wire

/* zipaxi_debug.sv */
/*
 * Debug and control wrapper for the CPU core.
 * An AXI-lite slave on one side, the core debug port on the other.
 */
`default_nettype none

module zipaxi_debug (
	input  wire logic                             S_AXI_ACLK,
	input  wire logic                             S_AXI_ARESETN,
	input  wire logic                             i_interrupt,
	input  wire logic                             i_cpu_reset,
	// AXI-lite debug slave
	input  wire logic                             i_awvalid,
	output logic                                  o_awready,
	input  wire logic [zip_dbg_pkg::DBG_ADDR_W-1:0] i_awaddr,
	input  wire logic                             i_wvalid,
	output logic                                  o_wready,
	input  wire logic [zip_dbg_pkg::DBG_DATA_W-1:0] i_wdata,
	input  wire logic [zip_dbg_pkg::DBG_STRB_W-1:0] i_wstrb,
	output logic                                  o_bvalid,
	input  wire logic                             i_bready,
	input  wire logic                             i_arvalid,
	output logic                                  o_arready,
	input  wire logic [zip_dbg_pkg::DBG_ADDR_W-1:0] i_araddr,
	output logic                                  o_rvalid,
	input  wire logic                             i_rready,
	output logic [zip_dbg_pkg::DBG_DATA_W-1:0]    o_rdata,
	// Core debug port
	output logic                                  o_core_we,
	output logic [zip_dbg_pkg::REG_IDX_W-1:0]     o_core_wreg,
	output logic [zip_dbg_pkg::DBG_DATA_W-1:0]    o_core_wdata,
	output logic [zip_dbg_pkg::REG_IDX_W-1:0]     o_core_rreg,
	output logic                                  o_core_halt,
	output logic                                  o_core_reset,
	output logic                                  o_core_clear_cache,
	input  wire logic [zip_dbg_pkg::DBG_DATA_W-1:0] i_core_rdata,
	input  wire logic                             i_core_stall,
	input  wire logic                             i_core_break,
	input  wire logic [zip_dbg_pkg::CC_W-1:0]     i_core_cc
);
	import zip_dbg_pkg::*;

	logic [DBG_DATA_W-1:0] status;

	dbg_req_if req ();

	dbg_write_path u_wr (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_awvalid, .o_awready, .i_awaddr,
		.i_wvalid, .o_wready, .i_wdata, .i_wstrb,
		.o_bvalid, .i_bready,
		.i_core_stall, .o_core_we, .o_core_wreg, .o_core_wdata,
		.req(req.wr)
	);

	dbg_read_path u_rd (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_arvalid, .o_arready, .i_araddr,
		.o_rvalid, .i_rready, .o_rdata,
		.o_core_rreg, .i_core_rdata,
		.i_status(status)
	);

	cpu_control u_ctl (
		.S_AXI_ACLK, .S_AXI_ARESETN,
		.i_cpu_reset, .i_interrupt, .i_core_break, .i_core_stall, .i_core_cc,
		.req(req.ctl),
		.o_core_reset, .o_core_halt, .o_core_clear_cache,
		.o_status(status)
	);

endmodule

`default_nettype wire

/* tb_zipaxi_debug.sv */
/*
 * Testbench for the AXI-lite CPU debug wrapper.
 * Operations and expected values come from the test data file. The core
 * debug port is modelled by a register array. BREADY, RREADY and core
 * stalls turn random once the data file switches that mode on.
 */
`default_nettype none

module tb_zipaxi_debug;
	import zip_dbg_pkg::*;

	localparam int CLK_PERIOD      = 40;
	localparam int RESET_CYCLES    = 16;
	localparam int MAX_TESTS       = 64;
	localparam int CYCLES_PER_TEST = 200;
	localparam int WAIT_LIMIT      = 100;

	logic S_AXI_ACLK, S_AXI_ARESETN;
	logic irq, cpu_reset, stall, brk;
	logic [CC_W-1:0] cc;
	logic awvalid, wvalid, bready, arvalid, rready;
	logic [DBG_ADDR_W-1:0] awaddr, araddr;
	logic [DBG_DATA_W-1:0] wdata;
	logic [DBG_STRB_W-1:0] wstrb;
	logic awready, wready, bvalid, arready, rvalid;
	logic core_we, core_halt, core_reset, core_clear_cache;
	logic [REG_IDX_W-1:0] core_wreg, core_rreg, exp_wreg;
	logic [DBG_DATA_W-1:0] rdata, core_wdata, core_rdata, exp_wdata, last_rdata;
	// Core register file
	logic [DBG_DATA_W-1:0] model [0:(1<<REG_IDX_W)-1];
	// Five words per test line
	logic [31:0] tdata [0:5*MAX_TESTS-1];
	logic [31:0] rng;
	logic rand_mode;
	int errors, passed, failed, n_tests;
	int b_cnt, r_cnt, we_cnt, halt_lo_cnt, reset_hi_cnt, cc_hi_cnt;

	zipaxi_debug DUT (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_interrupt(irq), .i_cpu_reset(cpu_reset),
		.i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr),
		.i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata), .i_wstrb(wstrb),
		.o_bvalid(bvalid), .i_bready(bready),
		.i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr),
		.o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata),
		.o_core_we(core_we), .o_core_wreg(core_wreg), .o_core_wdata(core_wdata),
		.o_core_rreg(core_rreg), .o_core_halt(core_halt), .o_core_reset(core_reset),
		.o_core_clear_cache(core_clear_cache), .i_core_rdata(core_rdata),
		.i_core_stall(stall), .i_core_break(brk), .i_core_cc(cc)
	);

	always #(CLK_PERIOD/2) S_AXI_ACLK = ~S_AXI_ACLK;

	// Core read port is combinational
	assign core_rdata = model[core_rreg];

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_value(input logic ok, input string what,
		input logic [31:0] got, input logic [31:0] want);
		assert (ok)
		else
		begin
			$display("** Error at %0t: %s, got %h expected %h", $time, what, got, want);
			errors++;
		end
	endtask

	task automatic check_done(input logic ok, input string what);
		assert (ok)
		else
		begin
			$display("Gave up at time %0t: %s", $time, what);
			errors++;
		end
	endtask

	// 0 reset, 1 halt, 2 clear cache
	function automatic logic control_level(input logic [31:0] sel);
		if (sel == 0)
			return core_reset;
		else if (sel == 1)
			return core_halt;
		return core_clear_cache;
	endfunction

	//////////////////////////////
	// Random back-pressure
	//////////////////////////////

	always @(posedge S_AXI_ACLK)
	begin
		if (rand_mode)
		begin
			rng = next_random(rng);
			// Ready about 3 in 4, stall about 1 in 4
			bready <= rng[0] | rng[1];
			rready <= rng[2] | rng[3];
			stall  <= rng[4] & rng[5];
		end
		else
		begin
			bready <= 1'b1;
			rready <= 1'b1;
			stall  <= 1'b0;
		end
	end

	// Monitors sample on the falling edge
	always @(negedge S_AXI_ACLK)
	begin
		if (S_AXI_ARESETN)
		begin
			if (bvalid && bready)
				b_cnt++;
			if (rvalid && rready)
			begin
				r_cnt++;
				last_rdata = rdata;
			end
			// Core takes the write when not stalled
			if (core_we && !stall)
			begin
				check_value(core_wreg == exp_wreg, "core write index", core_wreg, exp_wreg);
				check_value(core_wdata == exp_wdata, "core write data", core_wdata, exp_wdata);
				model[core_wreg] = core_wdata;
				we_cnt++;
			end
			if (!core_halt)
				halt_lo_cnt++;
			if (core_reset)
				reset_hi_cnt++;
			if (core_clear_cache)
				cc_hi_cnt++;
		end
	end

	//////////////////////////////
	// Operations
	//////////////////////////////

	// Expected value bits are 0 final halt, 1 halt seen low, 2 reset seen,
	// 3 clear cache seen and 4 final reset
	task automatic run_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [31:0] strb, input logic [31:0] expv);
		int b0, w0, h0, s0, c0, n;
		logic aw_pend, w_pend, reg_wr;
		logic [4:0] flags;
		b0 = b_cnt;
		w0 = we_cnt;
		h0 = halt_lo_cnt;
		s0 = reset_hi_cnt;
		c0 = cc_hi_cnt;
		reg_wr = (strb[DBG_STRB_W-1:0] != '0) && !addr[DBG_LSB + CTL_SEL_BIT];
		exp_wreg = addr[DBG_LSB +: REG_IDX_W];
		exp_wdata = data;
		awaddr <= addr[DBG_ADDR_W-1:0];
		wdata <= data;
		wstrb <= strb[DBG_STRB_W-1:0];
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		aw_pend = 1'b1;
		w_pend = 1'b1;
		n = 0;
		while ((aw_pend || w_pend) && n < WAIT_LIMIT)
		begin
			@(posedge S_AXI_ACLK);
			n++;
			if (aw_pend && awready)
			begin
				aw_pend = 1'b0;
				awvalid <= 1'b0;
			end
			if (w_pend && wready)
			begin
				w_pend = 1'b0;
				wvalid <= 1'b0;
			end
		end
		check_done(!aw_pend && !w_pend, "write address or data was never accepted");
		n = 0;
		while ((b_cnt == b0 || (reg_wr && we_cnt == w0)) && n < WAIT_LIMIT)
		begin
			@(posedge S_AXI_ACLK);
			n++;
		end
		check_done(b_cnt != b0, "no write response arrived");
		check_done(!reg_wr || we_cnt != w0, "the core never took the register write");
		// Settle and look for extra responses
		repeat (6) @(posedge S_AXI_ACLK);
		check_value(b_cnt - b0 == 1, "write responses per write", b_cnt - b0, 1);
		check_value((we_cnt - w0) == (reg_wr ? 1 : 0), "core writes per write",
			we_cnt - w0, reg_wr);
		flags = {core_reset, cc_hi_cnt != c0, reset_hi_cnt != s0, halt_lo_cnt != h0, core_halt};
		check_value(flags == expv[4:0], "control outputs after write", flags, expv);
	endtask

	// Data column is the compare mask
	task automatic run_read(input logic [31:0] addr, input logic [31:0] mask,
		input logic [31:0] expv);
		int r0, n;
		logic pend;
		logic [REG_IDX_W-1:0] idx;
		r0 = r_cnt;
		idx = addr[DBG_LSB +: REG_IDX_W];
		araddr <= addr[DBG_ADDR_W-1:0];
		arvalid <= 1'b1;
		pend = 1'b1;
		n = 0;
		while (pend && n < WAIT_LIMIT)
		begin
			@(posedge S_AXI_ACLK);
			n++;
			if (arready)
			begin
				pend = 1'b0;
				arvalid <= 1'b0;
			end
		end
		check_done(!pend, "read address was never accepted");
		n = 0;
		while (r_cnt == r0 && n < WAIT_LIMIT)
		begin
			@(posedge S_AXI_ACLK);
			n++;
		end
		check_done(r_cnt != r0, "no read response arrived");
		repeat (4) @(posedge S_AXI_ACLK);
		check_value(r_cnt - r0 == 1, "read responses per read", r_cnt - r0, 1);
		check_value((last_rdata & mask) == (expv & mask), "read data", last_rdata, expv);
		if (!addr[DBG_LSB + CTL_SEL_BIT])
			check_value(last_rdata == model[idx], "read data against core model",
				last_rdata, model[idx]);
	endtask

	task automatic wait_level(input logic [31:0] sel, input logic [31:0] limit,
		input logic [31:0] level);
		int n;
		n = 0;
		while (control_level(sel) !== level[0] && n < limit)
		begin
			@(posedge S_AXI_ACLK);
			n++;
		end
		check_done(control_level(sel) === level[0],
			"a control output did not reach the expected level");
	endtask

	//////////////////////////////
	// Watchdog
	//////////////////////////////

	initial
	begin
		wait (n_tests > 0);
		#((n_tests * CYCLES_PER_TEST + RESET_CYCLES) * CLK_PERIOD);
		$display("Run stopped by the watchdog, a test never finished");
		$display("** FAIL **");
		$finish;
	end

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial
	begin
		int i, k, e0, n;
		logic [31:0] kind, addr, data, strb, expv;
		S_AXI_ACLK = 1'b0;
		S_AXI_ARESETN = 1'b0;
		{irq, cpu_reset, stall, brk, cc} = '0;
		{awvalid, wvalid, arvalid} = '0;
		bready = 1'b1;
		rready = 1'b1;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		wstrb = '0;
		exp_wreg = '0;
		exp_wdata = '0;
		last_rdata = '0;
		rng = 32'd62996;
		rand_mode = 1'b0;
		{errors, passed, failed, n_tests} = '0;
		{b_cnt, r_cnt, we_cnt, halt_lo_cnt, reset_hi_cnt, cc_hi_cnt} = '0;
		// Fill depends on the whole index
		for (k = 0; k < (1 << REG_IDX_W); k++)
			model[k] = 32'h5a5a_0000 ^ (k * 32'h0001_0203);
		$readmemh("zipaxi_debug_testdata.txt", tdata);
		// Count the lines first so the watchdog sees the final total
		k = 0;
		while (k < MAX_TESTS && tdata[5*k] !== 32'bx)
			k++;
		n_tests = k;
		check_done(n_tests > 0, "no test data was loaded");

		// o_core_reset held through the whole bus reset
		e0 = errors;
		for (k = 0; k < RESET_CYCLES; k++)
		begin
			@(posedge S_AXI_ACLK);
			if (k > 0)
				check_value(core_reset == 1'b1, "core reset during bus reset", core_reset, 1);
		end
		check_value({bvalid, rvalid, core_we} == 3'b000, "outputs after reset",
			{bvalid, rvalid, core_we}, 0);
		S_AXI_ARESETN <= 1'b1;
		// Skip the release edge and count the hold
		@(posedge S_AXI_ACLK);
		@(posedge S_AXI_ACLK);
		n = 0;
		while (core_reset && n < 4 * RESET_DURATION)
		begin
			n++;
			@(posedge S_AXI_ACLK);
		end
		check_value(n == RESET_DURATION, "core reset hold cycles", n, RESET_DURATION);
		if (errors == e0)
			passed++;
		else
			failed++;
		$display("test 0 reset hold: %s", (errors == e0) ? "passed" : "failed");

		for (i = 0; i < n_tests; i++)
		begin
			e0 = errors;
			kind = tdata[5*i];
			addr = tdata[5*i+1];
			data = tdata[5*i+2];
			strb = tdata[5*i+3];
			expv = tdata[5*i+4];
			@(posedge S_AXI_ACLK);
			case (kind)
				0:
				begin
					rand_mode <= data[0];
					repeat (3) @(posedge S_AXI_ACLK);
				end
				1: run_write(addr, data, strb, expv);
				2: run_read(addr, data, expv);
				3: wait_level(addr, data, expv);
				4:
				begin
					brk <= data[0];
					irq <= data[1];
					cc  <= data[4 +: CC_W];
					repeat (2) @(posedge S_AXI_ACLK);
				end
				default: check_done(1'b0, "unknown operation kind in the test data");
			endcase
			if (errors == e0)
				passed++;
			else
				failed++;
			$display("test %0d kind %0h addr %h: %s", i + 1, kind, addr[7:0],
				(errors == e0) ? "passed" : "failed");
		end

		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			passed + failed, passed, failed, errors);
		if (errors == 0 && failed == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

/* zipaxi_debug_testdata.txt */
// kind addr data strb expected, all hex; kind 0 random mode, 1 write,
// 2 read (data is mask), 3 wait for reset/halt/cc (data is cycle limit), 4 break/irq/cc
2 80 00000440 0 00000000
1 14 12345678 f 00000003
2 14 ffffffff 0 12345678
1 80 00000000 f 00000002
1 80 00000400 f 00000003
1 80 00000400 f 00000001
1 80 00000100 f 00000003
1 80 00000c00 f 00000009
1 80 00000440 f 00000005
2 80 0001f6c0 0 00000600
1 80 00000000 f 00000002
4 00 00000053 0 00000000
3 00 0000000a 0 00000001
2 80 0001f6c0 0 0001d2c0
4 00 00000000 0 00000000
3 00 0000000a 0 00000000
0 00 00000001 0 00000000
1 0c cafef00d f 00000003
1 7c 0badc0de f 00000001
2 0c ffffffff 0 cafef00d
2 7c ffffffff 0 0badc0de
1 0c 11111111 0 00000001
2 0c ffffffff 0 cafef00d
2 14 ffffffff 0 12345678
2 80 0001f4c0 0 00000400
1 00 00000001 f 00000001
2 00 ffffffff 0 00000001

/* project.f */
zip_dbg_pkg.sv
dbg_req_if.sv
skid_buffer.sv
dbg_write_path.sv
dbg_read_path.sv
cpu_control.sv
zipaxi_debug.sv
tb_zipaxi_debug.sv
